// ==== project.f ====
+incdir+verif
common/cpuPkg.sv
src/instFetch.sv
decoder/decoder.sv
src/regFile.sv
src/robAlloc.sv
src/frontEnd.sv
verif/tbFrontEnd.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tbFrontEnd -o simFrontEnd
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simFrontEnd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// ==== verif/tbVectors.svh ====
// columns: instruction, address, expected op, expected imm, predicted taken, next dispatch pc
// rows are in dispatch order along the predicted path
addRow(encU('h12345000, 1, OPC_LUI), 'h00, OP_LUI, 'h12345000, 0, 'h04);
addRow(encU('hfffff000, 2, OPC_AUIPC), 'h04, OP_AUIPC, 'hfffff000, 0, 'h08);
addRow(encJ('h38, 3), 'h08, OP_JAL, 'h38, 1, 'h40);
addRow(encI('hfff, 1, 0, 1, OPC_OPIMM), 'h40, OP_ADDI, 'hffffffff, 0, 'h44);
addRow(encI('h005, 1, 2, 2, OPC_OPIMM), 'h44, OP_SLTI, 'h5, 0, 'h48);
addRow(encI('h7ff, 2, 3, 4, OPC_OPIMM), 'h48, OP_SLTIU, 'h7ff, 0, 'h4c);
addRow(encI('h800, 0, 4, 5, OPC_OPIMM), 'h4c, OP_XORI, 'hfffff800, 0, 'h50);
addRow(encI('h0f0, 3, 6, 1, OPC_OPIMM), 'h50, OP_ORI, 'hf0, 0, 'h54);
addRow(encI('h0ff, 4, 7, 2, OPC_OPIMM), 'h54, OP_ANDI, 'hff, 0, 'h58);
addRow(encI('h003, 1, 1, 3, OPC_OPIMM), 'h58, OP_SLLI, 'h3, 0, 'h5c);
addRow(encI('h007, 2, 5, 4, OPC_OPIMM), 'h5c, OP_SRLI, 'h7, 0, 'h60);
addRow(encI('h41f, 3, 5, 5, OPC_OPIMM), 'h60, OP_SRAI, 'h41f, 0, 'h64);
addRow(encB('hffffffa8, 2, 1, 0), 'h64, OP_BEQ, 'hffffffa8, 1, 'h0c);  // back into the hole
addRow(encR('h00, 3, 2, 0, 1), 'h0c, OP_ADD, 'h0, 0, 'h10);
addRow(encR('h20, 1, 1, 0, 2), 'h10, OP_SUB, 'h0, 0, 'h14);
addRow(encR('h00, 4, 2, 1, 3), 'h14, OP_SLL, 'h0, 0, 'h18);
addRow(encR('h00, 5, 3, 2, 4), 'h18, OP_SLT, 'h0, 0, 'h1c);
addRow(encR('h00, 1, 0, 3, 5), 'h1c, OP_SLTU, 'h0, 0, 'h20);
addRow(encR('h00, 2, 1, 4, 1), 'h20, OP_XOR, 'h0, 0, 'h24);
addRow(encR('h00, 4, 3, 5, 2), 'h24, OP_SRL, 'h0, 0, 'h28);
addRow(encR('h20, 0, 5, 5, 3), 'h28, OP_SRA, 'h0, 0, 'h2c);
addRow(encR('h00, 5, 1, 6, 4), 'h2c, OP_OR, 'h0, 0, 'h30);
addRow(encR('h00, 3, 2, 7, 5), 'h30, OP_AND, 'h0, 0, 'h34);
addRow(encB('h10, 2, 1, 1), 'h34, OP_BNE, 'h10, 0, 'h38);
addRow(encJ('h30, 0), 'h38, OP_JAL, 'h30, 1, 'h68);
addRow(encJ('h10, 6), 'h68, OP_JAL, 'h10, 1, 'h78);
addRow(encB('hfffffff4, 5, 1, 6), 'h78, OP_BLTU, 'hfffffff4, 1, 'h6c);
addRow(encB('h14, 4, 3, 4), 'h6c, OP_BLT, 'h14, 0, 'h70);
addRow(encB('h10, 0, 5, 5), 'h70, OP_BGE, 'h10, 0, 'h74);
addRow(encJ('h0c, 7), 'h74, OP_JAL, 'hc, 1, 'h80);
addRow(encI('h000, 3, 0, 7, OPC_JALR), 'h80, OP_JALR, 'h0, 0, 'h84);  // x7 renamed again
addRow(encI('h004, 2, 0, 1, OPC_LOAD), 'h84, OP_LB, 'h4, 0, 'h88);
addRow(encI('hffe, 1, 1, 2, OPC_LOAD), 'h88, OP_LH, 'hfffffffe, 0, 'h8c);
addRow(encI('h010, 0, 2, 3, OPC_LOAD), 'h8c, OP_LW, 'h10, 0, 'h90);
addRow(encI('h001, 5, 4, 4, OPC_LOAD), 'h90, OP_LBU, 'h1, 0, 'h94);
addRow(encI('h7fe, 4, 5, 5, OPC_LOAD), 'h94, OP_LHU, 'h7fe, 0, 'h98);
addRow(encS('h008, 1, 2, 0), 'h98, OP_SB, 'h8, 0, 'h9c);
addRow(encS('hfffffffc, 3, 4, 1), 'h9c, OP_SH, 'hfffffffc, 0, 'ha0);
addRow(encS('h100, 5, 0, 2), 'ha0, OP_SW, 'h100, 0, 'ha4);
addRow('hffffffff, 'ha4, OP_NOP, 'h0, 0, 'ha8);  // illegal opcode
addRow(encB('h40, 1, 2, 7), 'ha8, OP_BGEU, 'h40, 0, 'hac);

// ==== verif/tbFrontEnd.sv ====
`default_nettype none

module tbFrontEnd
    import cpuPkg::*;
();

    typedef struct {
        logic [31:0]     inst;
        logic [31:0]     addr;
        logic [OP_W-1:0] op;
        logic [31:0]     imm;
        logic            pd;
        logic [31:0]     nextPc;
    } progRow_s;

    logic              clk;
    logic              rst;
    logic [XLEN-1:0]   imemAddr;
    instWord_u         imemData;
    logic              commitEn;
    logic [XLEN-1:0]   commitValue;
    logic              dispEn;
    logic [OP_W-1:0]   dispOp;
    logic [XLEN-1:0]   dispImm;
    logic [XLEN-1:0]   dispPc;
    logic              dispPd;
    logic [NAME_W-1:0] dispRdName;
    logic [TAG_W-1:0]  dispRdTag;
    logic [XLEN-1:0]   dispRs1Value;
    logic [TAG_W-1:0]  dispRs1Tag;
    logic              dispRs1Ready;
    logic [XLEN-1:0]   dispRs2Value;
    logic [TAG_W-1:0]  dispRs2Tag;
    logic              dispRs2Ready;

    progRow_s          rows[$];
    logic [31:0]       progMem [logic [31:0]];
    bit                loaded;
    int                errOp;
    int                errWord;
    int                errTag;
    int                errOther;

    // reference rename model
    logic [XLEN-1:0]   refValue [32];
    logic [TAG_W-1:0]  refTag [32];
    logic              refBusy [32];
    logic [TAG_W-1:0]  tagQ[$];
    int                nameQ[$];
    logic [TAG_W-1:0]  expTag;
    bit                retAValid;
    logic [TAG_W-1:0]  retATag;
    int                retAName;
    logic [XLEN-1:0]   retAValue;
    bit                retBValid;
    logic [TAG_W-1:0]  retBTag;
    int                retBName;
    logic [XLEN-1:0]   retBValue;

    logic [31:0]       rngState;
    bit                hold;  // commits withheld until the buffer fills
    int                holdCycles;
    int                row;
    int                dispCount;
    int                total;

    frontEnd u_frontEnd (.*);

    always #2 clk = ~clk;

    // ========================================
    // program encoding
    // ========================================
    function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] encI(logic [31:0] imm, int rs1, int f3, int rd,
                                         logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encS(logic [31:0] imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] encB(logic [31:0] imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encU(logic [31:0] imm, int rd, logic [6:0] opc);
        return {imm[31:12], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encJ(logic [31:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic addRow(logic [31:0] inst, logic [31:0] addr, logic [OP_W-1:0] op,
                          logic [31:0] imm, int pd, logic [31:0] nextPc);
        progRow_s r;
        r.inst   = inst;
        r.addr   = addr;
        r.op     = op;
        r.imm    = imm;
        r.pd     = pd[0];
        r.nextPc = nextPc;
        rows.push_back(r);
        progMem[addr] = inst;
    endtask

    task automatic loadProgram;
        `include "tbVectors.svh"
    endtask

    function automatic logic [31:0] fetchWord(logic [31:0] a);
        if ($isunknown(a)) begin
            return 32'h00000013;  // addi x0, x0, 0
        end
        if (!progMem.exists(a)) begin
            return {a[31:12] ^ {8'h00, a[11:0]}, 5'd0, OPC_LUI};  // lui x0, folded address
        end
        return progMem[a];
    endfunction

    function automatic logic [31:0] drawRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // operand usage by operation class
    function automatic bit usesRd(logic [OP_W-1:0] op);
        return !(op == OP_NOP || (op >= OP_BEQ && op <= OP_BGEU) ||
                 (op >= OP_SB && op <= OP_SW));
    endfunction

    function automatic bit usesRs1(logic [OP_W-1:0] op);
        return !(op == OP_NOP || op == OP_LUI || op == OP_AUIPC || op == OP_JAL);
    endfunction

    function automatic bit usesRs2(logic [OP_W-1:0] op);
        return (op >= OP_BEQ && op <= OP_BGEU) || (op >= OP_SB && op <= OP_SW) ||
               (op >= OP_ADD && op <= OP_AND);
    endfunction

    // ========================================
    // compare tasks
    // ========================================
    task automatic checkOp(logic [OP_W-1:0] act, logic [OP_W-1:0] exp, string what);
        if (act !== exp) begin
            errOp++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic checkWord(logic [XLEN-1:0] act, logic [XLEN-1:0] exp, string what);
        if (act !== exp) begin
            errWord++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, act, exp);
        end
    endtask

    task automatic checkTag(logic [TAG_W-1:0] act, logic [TAG_W-1:0] exp, string what);
        if (act !== exp) begin
            errTag++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, act, exp);
        end
    endtask

    // ready sources carry a value, pending ones a tag
    task automatic checkOperand(logic ready, logic [XLEN-1:0] value, logic [TAG_W-1:0] tag,
                                int name, string what);
        checkWord(XLEN'(ready), XLEN'(!refBusy[name]), {what, " ready"});
        if (refBusy[name]) begin
            checkTag(tag, refTag[name], {what, " tag"});
        end else begin
            checkWord(value, refValue[name], {what, " value"});
        end
    endtask

    task automatic checkDispatch(output int rd);
        progRow_s    r;
        logic [31:0] expPc;
        int          rs1;
        int          rs2;
        string       id;
        r     = rows[row];
        expPc = (row == 0) ? 32'h0 : rows[row-1].nextPc;
        rd    = usesRd(r.op) ? int'(r.inst[11:7]) : 0;
        rs1   = usesRs1(r.op) ? int'(r.inst[19:15]) : 0;
        rs2   = usesRs2(r.op) ? int'(r.inst[24:20]) : 0;
        id    = $sformatf("row %0d", row);
        checkOp(dispOp, r.op, {id, " op"});
        checkWord(dispImm, r.imm, {id, " imm"});
        checkWord(dispPc, expPc, {id, " pc"});
        checkWord(XLEN'(dispPd), XLEN'(r.pd), {id, " prediction"});
        checkWord(XLEN'(dispRdName), XLEN'(rd), {id, " rd name"});
        checkTag(dispRdTag, expTag, {id, " rd tag"});
        checkOperand(dispRs1Ready, dispRs1Value, dispRs1Tag, rs1, {id, " rs1"});
        checkOperand(dispRs2Ready, dispRs2Value, dispRs2Tag, rs2, {id, " rs2"});
    endtask

    // one clock edge of the reference model, run on the falling edge after it
    task automatic stepModel;
        int          rd;
        bit          renameNow;
        logic [31:0] r;
        rd        = 0;
        renameNow = 0;
        if (dispEn) begin
            if (hold && dispCount >= ROB_DEPTH) begin
                errOther++;
                $display("dispatch %0d went out while all tags were allocated", dispCount + 1);
            end
            checkDispatch(rd);
            renameNow = 1;
            tagQ.push_back(expTag);
            nameQ.push_back(rd);
            row++;
            dispCount++;
        end
        // retire write lands on this edge, before the rename
        if (retBValid && retBName != 0 && refBusy[retBName] && refTag[retBName] == retBTag) begin
            refValue[retBName] = retBValue;
            refBusy[retBName]  = 1'b0;
        end
        if (renameNow && rd != 0) begin
            refBusy[rd] = 1'b1;
            refTag[rd]  = expTag;
        end
        if (renameNow) expTag = expTag + TAG_W'(1);
        retBValid = retAValid;
        retBTag   = retATag;
        retBName  = retAName;
        retBValue = retAValue;
        retAValid = 0;
        commitEn  = 1'b0;
        if (hold) begin
            if (dispCount >= ROB_DEPTH) holdCycles++;
            if (holdCycles == 12) hold = 0;
        end else begin
            r = drawRandom();
            if (r[0] && tagQ.size() > 0) begin
                r = drawRandom();
                commitEn    = 1'b1;
                commitValue = r;
                retAValid   = 1;
                retATag     = tagQ.pop_front();
                retAName    = nameQ.pop_front();
                retAValue   = r;
            end
        end
    endtask

    always @(negedge clk) begin
        imemData = fetchWord(imemAddr);
    end

    // ========================================
    // main sequence
    // ========================================
    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        commitEn    = 1'b0;
        commitValue = '0;
        imemData    = fetchWord(32'h0);
        rngState    = 32'hbdea;
        hold        = 1;
        expTag      = '0;
        for (int k = 0; k < 32; k++) begin
            refValue[k] = '0;
            refTag[k]   = '0;
            refBusy[k]  = 1'b0;
        end
        loadProgram();
        loaded = 1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (row < rows.size()) begin
            @(negedge clk);
            stepModel();
        end
        total = errOp + errWord + errTag + errOther;
        $display("errors: op %0d, word %0d, tag %0d, other %0d",
                 errOp, errWord, errTag, errOther);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (rows.size() * 40 + 16) @(posedge clk);
        $display("timeout: dispatch stream stopped before the last table row");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/frontEnd.sv ====
`default_nettype none

module frontEnd
    import cpuPkg::*;
(
    input  logic              clk,
    input  logic              rst,

    output logic [XLEN-1:0]   imemAddr,
    input  instWord_u         imemData,

    input  logic              commitEn,
    input  logic [XLEN-1:0]   commitValue,

    output logic              dispEn,
    output logic [OP_W-1:0]   dispOp,
    output logic [XLEN-1:0]   dispImm,
    output logic [XLEN-1:0]   dispPc,
    output logic              dispPd,
    output logic [NAME_W-1:0] dispRdName,
    output logic [TAG_W-1:0]  dispRdTag,
    output logic [XLEN-1:0]   dispRs1Value,
    output logic [TAG_W-1:0]  dispRs1Tag,
    output logic              dispRs1Ready,
    output logic [XLEN-1:0]   dispRs2Value,
    output logic [TAG_W-1:0]  dispRs2Tag,
    output logic              dispRs2Ready
);

    logic              rdy;

    // fetch to decode
    logic              infEn;
    instWord_u         infInst;
    logic [XLEN-1:0]   infPc;
    logic              infPd;

    // decode to rename
    logic              rfEn;
    logic [NAME_W-1:0] rfRs1Name;
    logic [NAME_W-1:0] rfRs2Name;
    logic [NAME_W-1:0] rfRdName;
    logic [OP_W-1:0]   rfOp;
    logic [XLEN-1:0]   rfPc;
    logic [XLEN-1:0]   rfImm;
    logic              rfPd;

    // reorder buffer side
    logic              robEn;
    logic [NAME_W-1:0] robRdName;
    logic [TAG_W-1:0]  allocTag;
    logic              retireEn;
    logic [TAG_W-1:0]  retireTag;
    logic [NAME_W-1:0] retireName;
    logic [XLEN-1:0]   retireValue;

    instFetch u_instFetch (.*);

    decoder u_decoder (.*);

    regFile u_regFile (.*);

    robAlloc u_robAlloc (.*);

endmodule

`default_nettype wire

// ==== src/robAlloc.sv ====
`default_nettype none

module robAlloc
    import cpuPkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              robEn,
    input  logic [NAME_W-1:0] robRdName,
    input  logic              commitEn,
    input  logic [XLEN-1:0]   commitValue,

    output logic              rdy,
    output logic [TAG_W-1:0]  allocTag,
    output logic              retireEn,
    output logic [TAG_W-1:0]  retireTag,
    output logic [NAME_W-1:0] retireName,
    output logic [XLEN-1:0]   retireValue
);

    logic [TAG_W-1:0]  head;
    logic [TAG_W-1:0]  tail;
    logic [TAG_W:0]    count;  // 0 .. ROB_DEPTH
    logic [NAME_W-1:0] entryName [ROB_DEPTH];
    logic              doAlloc;
    logic              doCommit;

    assign rdy      = (count != (TAG_W+1)'(ROB_DEPTH));
    assign allocTag = tail;
    assign doAlloc  = robEn && rdy;
    assign doCommit = commitEn && (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            retireEn <= 1'b0;
        end else begin
            if (doAlloc) tail <= tail + 1'b1;
            if (doCommit) head <= head + 1'b1;
            count    <= count + (TAG_W+1)'(doAlloc) - (TAG_W+1)'(doCommit);
            retireEn <= doCommit;
        end
    end

    always_ff @(posedge clk) begin
        if (doAlloc) begin
            entryName[tail] <= robRdName;
        end
        if (doCommit) begin
            retireTag   <= head;
            retireName  <= entryName[head];
            retireValue <= commitValue;
        end
    end

    // occupancy stays within depth, a full buffer has tail wrapped onto head
    aNoAllocFull: assert property (@(posedge clk) disable iff (rst)
        count <= (TAG_W+1)'(ROB_DEPTH) && (rdy || tail == head))
        else $error("allocation while full");

    aNoCommitEmpty: assert property (@(posedge clk) disable iff (rst)
        commitEn |-> count != '0)
        else $error("commit while empty");

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none

module regFile
    import cpuPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              rfEn,
    input  logic [NAME_W-1:0] rfRs1Name,
    input  logic [NAME_W-1:0] rfRs2Name,
    input  logic [NAME_W-1:0] rfRdName,
    input  logic [OP_W-1:0]   rfOp,
    input  logic [XLEN-1:0]   rfPc,
    input  logic [XLEN-1:0]   rfImm,
    input  logic              rfPd,
    input  logic [TAG_W-1:0]  allocTag,

    input  logic              retireEn,
    input  logic [TAG_W-1:0]  retireTag,
    input  logic [NAME_W-1:0] retireName,
    input  logic [XLEN-1:0]   retireValue,

    output logic              dispEn,
    output logic [OP_W-1:0]   dispOp,
    output logic [XLEN-1:0]   dispImm,
    output logic [XLEN-1:0]   dispPc,
    output logic              dispPd,
    output logic [NAME_W-1:0] dispRdName,
    output logic [TAG_W-1:0]  dispRdTag,
    output logic [XLEN-1:0]   dispRs1Value,
    output logic [TAG_W-1:0]  dispRs1Tag,
    output logic              dispRs1Ready,
    output logic [XLEN-1:0]   dispRs2Value,
    output logic [TAG_W-1:0]  dispRs2Tag,
    output logic              dispRs2Ready
);

    logic [XLEN-1:0]  regValue [32];
    logic [TAG_W-1:0] regTag   [32];
    logic [31:0]      regBusy;
    logic             doDisp;
    logic             tagMatch;

    assign doDisp   = rfEn && rdy;
    assign tagMatch = regBusy[retireName] && (regTag[retireName] == retireTag);

    // ========================================
    // architectural state
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            regBusy <= '0;
            for (int k = 0; k < 32; k++) begin
                regValue[k] <= '0;
            end
        end else begin
            if (retireEn && retireName != '0 && tagMatch) begin
                regValue[retireName] <= retireValue;
                regBusy[retireName]  <= 1'b0;
            end
            // a new rename overrides a retire of the same register
            if (doDisp && rfRdName != '0) begin
                regBusy[rfRdName] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doDisp && rfRdName != '0) begin
            regTag[rfRdName] <= allocTag;
        end
    end

    // ========================================
    // dispatch packet
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            dispEn <= 1'b0;
        end else begin
            dispEn <= doDisp;
        end
    end

    always_ff @(posedge clk) begin
        if (doDisp) begin
            dispOp       <= rfOp;
            dispImm      <= rfImm;
            dispPc       <= rfPc;
            dispPd       <= rfPd;
            dispRdName   <= rfRdName;
            dispRdTag    <= allocTag;
            dispRs1Ready <= !regBusy[rfRs1Name];
            dispRs1Value <= regBusy[rfRs1Name] ? '0 : regValue[rfRs1Name];
            dispRs1Tag   <= regBusy[rfRs1Name] ? regTag[rfRs1Name] : '0;
            dispRs2Ready <= !regBusy[rfRs2Name];
            dispRs2Value <= regBusy[rfRs2Name] ? '0 : regValue[rfRs2Name];
            dispRs2Tag   <= regBusy[rfRs2Name] ? regTag[rfRs2Name] : '0;
        end
    end

    // x0 stays zero and idle across retires aimed at it
    aX0Retire: assert property (@(posedge clk) disable iff (rst)
        retireEn && retireName == '0 |=> regValue[0] == '0 && !regBusy[0])
        else $error("retire wrote x0");

endmodule

`default_nettype wire

// ==== decoder/decoder.sv ====
`default_nettype none

module decoder
    import cpuPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              infEn,
    input  instWord_u         infInst,
    input  logic [XLEN-1:0]   infPc,
    input  logic              infPd,

    output logic              robEn,
    output logic [NAME_W-1:0] robRdName,

    output logic              rfEn,
    output logic [NAME_W-1:0] rfRs1Name,
    output logic [NAME_W-1:0] rfRs2Name,
    output logic [NAME_W-1:0] rfRdName,
    output logic [OP_W-1:0]   rfOp,
    output logic [XLEN-1:0]   rfPc,
    output logic [XLEN-1:0]   rfImm,
    output logic              rfPd
);

    logic [2:0]        funct3;
    logic              alt;  // inst bit 30
    logic [OP_W-1:0]   op;
    logic [XLEN-1:0]   imm;
    logic              useRs1;
    logic              useRs2;
    logic              useRd;
    logic [NAME_W-1:0] rdName;

    assign funct3 = infInst.r.funct3;
    assign alt    = infInst.r.funct7[5];
    assign rdName = useRd ? infInst.r.rd : '0;

    // ========================================
    // operation and immediate
    // ========================================
    always_comb begin
        op     = OP_NOP;
        imm    = '0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        useRd  = 1'b0;
        case (infInst.r.opcode)
            OPC_LUI, OPC_AUIPC: begin
                op    = (infInst.r.opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
                imm   = immU(infInst);
                useRd = 1'b1;
            end
            OPC_JAL: begin
                op    = OP_JAL;
                imm   = immJ(infInst);
                useRd = 1'b1;
            end
            OPC_JALR: begin
                op     = (funct3 == 3'b000) ? OP_JALR : OP_NOP;
                imm    = immI(infInst);
                useRs1 = 1'b1;
                useRd  = 1'b1;
            end
            OPC_BRANCH: begin
                imm    = immB(infInst);
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_NOP;
                endcase
            end
            OPC_LOAD: begin
                imm    = immI(infInst);
                useRs1 = 1'b1;
                useRd  = 1'b1;
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_NOP;
                endcase
            end
            OPC_STORE: begin
                imm    = immS(infInst);
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_NOP;
                endcase
            end
            OPC_OPIMM: begin
                imm    = immI(infInst);
                useRs1 = 1'b1;
                useRd  = 1'b1;
                case (funct3)
                    3'b000:  op = OP_ADDI;
                    3'b010:  op = OP_SLTI;
                    3'b011:  op = OP_SLTIU;
                    3'b100:  op = OP_XORI;
                    3'b110:  op = OP_ORI;
                    3'b111:  op = OP_ANDI;
                    3'b001:  op = alt ? OP_NOP : OP_SLLI;
                    default: op = alt ? OP_SRAI : OP_SRLI;
                endcase
            end
            OPC_OP: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                useRd  = 1'b1;
                case ({alt, funct3})
                    4'b0000: op = OP_ADD;
                    4'b1000: op = OP_SUB;
                    4'b0001: op = OP_SLL;
                    4'b0010: op = OP_SLT;
                    4'b0011: op = OP_SLTU;
                    4'b0100: op = OP_XOR;
                    4'b0101: op = OP_SRL;
                    4'b1101: op = OP_SRA;
                    4'b0110: op = OP_OR;
                    4'b0111: op = OP_AND;
                    default: op = OP_NOP;
                endcase
            end
            default: op = OP_NOP;
        endcase

        // illegal encodings carry no operands
        if (op == OP_NOP) begin
            imm    = '0;
            useRs1 = 1'b0;
            useRs2 = 1'b0;
            useRd  = 1'b0;
        end
    end

    // ========================================
    // output registers
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            rfEn  <= 1'b0;
            robEn <= 1'b0;
        end else if (rdy) begin
            rfEn  <= infEn;
            robEn <= infEn;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            rfOp      <= op;
            rfImm     <= imm;
            rfPc      <= infPc;
            rfPd      <= infPd;
            rfRs1Name <= useRs1 ? infInst.r.rs1 : '0;
            rfRs2Name <= useRs2 ? infInst.r.rs2 : '0;
            rfRdName  <= rdName;
            robRdName <= rdName;
        end
    end

    // regFile and robAlloc must see the same instruction stream
    aEnPair: assert property (@(posedge clk) rfEn == robEn)
        else $error("rfEn and robEn differ");

endmodule

`default_nettype wire

// ==== src/instFetch.sv ====
`default_nettype none

module instFetch
    import cpuPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,

    output logic [XLEN-1:0] imemAddr,
    input  instWord_u       imemData,

    output logic            infEn,
    output instWord_u       infInst,
    output logic [XLEN-1:0] infPc,
    output logic            infPd
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] offset;
    logic [XLEN-1:0] nextPc;
    logic            predTaken;

    assign imemAddr = pc;

    // static prediction: jal always, branches only when backward
    always_comb begin
        predTaken = 1'b0;
        offset    = immB(imemData);
        case (imemData.r.opcode)
            OPC_JAL: begin
                predTaken = 1'b1;
                offset    = immJ(imemData);
            end
            OPC_BRANCH: begin
                predTaken = imemData.b.imm12;  // negative offset
            end
            default: begin
                predTaken = 1'b0;  // jalr falls through
            end
        endcase
        nextPc = predTaken ? pc + offset : pc + XLEN'(4);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= '0;
            infEn <= 1'b0;
        end else if (rdy) begin
            pc    <= nextPc;
            infEn <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            infInst <= imemData;
            infPc   <= pc;
            infPd   <= predTaken;
        end
    end

endmodule

`default_nettype wire

// ==== common/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // ========================================
    // widths
    // ========================================
    localparam int XLEN      = 32;
    localparam int NAME_W    = 5;
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;
    localparam int OP_W      = 6;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ========================================
    // internal operation codes
    // ========================================
    localparam logic [OP_W-1:0] OP_NOP   = 6'd0;
    localparam logic [OP_W-1:0] OP_LUI   = 6'd1;
    localparam logic [OP_W-1:0] OP_AUIPC = 6'd2;
    localparam logic [OP_W-1:0] OP_JAL   = 6'd3;
    localparam logic [OP_W-1:0] OP_JALR  = 6'd4;
    localparam logic [OP_W-1:0] OP_BEQ   = 6'd5;
    localparam logic [OP_W-1:0] OP_BNE   = 6'd6;
    localparam logic [OP_W-1:0] OP_BLT   = 6'd7;
    localparam logic [OP_W-1:0] OP_BGE   = 6'd8;
    localparam logic [OP_W-1:0] OP_BLTU  = 6'd9;
    localparam logic [OP_W-1:0] OP_BGEU  = 6'd10;
    localparam logic [OP_W-1:0] OP_LB    = 6'd11;
    localparam logic [OP_W-1:0] OP_LH    = 6'd12;
    localparam logic [OP_W-1:0] OP_LW    = 6'd13;
    localparam logic [OP_W-1:0] OP_LBU   = 6'd14;
    localparam logic [OP_W-1:0] OP_LHU   = 6'd15;
    localparam logic [OP_W-1:0] OP_SB    = 6'd16;
    localparam logic [OP_W-1:0] OP_SH    = 6'd17;
    localparam logic [OP_W-1:0] OP_SW    = 6'd18;
    localparam logic [OP_W-1:0] OP_ADDI  = 6'd19;
    localparam logic [OP_W-1:0] OP_SLTI  = 6'd20;
    localparam logic [OP_W-1:0] OP_SLTIU = 6'd21;
    localparam logic [OP_W-1:0] OP_XORI  = 6'd22;
    localparam logic [OP_W-1:0] OP_ORI   = 6'd23;
    localparam logic [OP_W-1:0] OP_ANDI  = 6'd24;
    localparam logic [OP_W-1:0] OP_SLLI  = 6'd25;
    localparam logic [OP_W-1:0] OP_SRLI  = 6'd26;
    localparam logic [OP_W-1:0] OP_SRAI  = 6'd27;
    localparam logic [OP_W-1:0] OP_ADD   = 6'd28;
    localparam logic [OP_W-1:0] OP_SUB   = 6'd29;
    localparam logic [OP_W-1:0] OP_SLL   = 6'd30;
    localparam logic [OP_W-1:0] OP_SLT   = 6'd31;
    localparam logic [OP_W-1:0] OP_SLTU  = 6'd32;
    localparam logic [OP_W-1:0] OP_XOR   = 6'd33;
    localparam logic [OP_W-1:0] OP_SRL   = 6'd34;
    localparam logic [OP_W-1:0] OP_SRA   = 6'd35;
    localparam logic [OP_W-1:0] OP_OR    = 6'd36;
    localparam logic [OP_W-1:0] OP_AND   = 6'd37;

    // ========================================
    // instruction formats
    // ========================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rInst_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iInst_s;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sInst_s;

    typedef struct packed {
        logic       imm12;  // sign
        logic [5:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;
        logic       imm11;
        logic [6:0] opcode;
    } bInst_s;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uInst_s;

    typedef struct packed {
        logic       imm20;  // sign
        logic [9:0] immLo;
        logic       imm11;
        logic [7:0] immHi;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jInst_s;

    typedef union packed {
        rInst_s r;
        iInst_s i;
        sInst_s s;
        bInst_s b;
        uInst_s u;
        jInst_s j;
    } instWord_u;

    // immediate builders
    function automatic logic [XLEN-1:0] immI(instWord_u w);
        return {{20{w.i.imm[11]}}, w.i.imm};
    endfunction

    function automatic logic [XLEN-1:0] immS(instWord_u w);
        return {{20{w.s.immHi[6]}}, w.s.immHi, w.s.immLo};
    endfunction

    function automatic logic [XLEN-1:0] immB(instWord_u w);
        return {{20{w.b.imm12}}, w.b.imm11, w.b.immHi, w.b.immLo, 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] immU(instWord_u w);
        return {w.u.imm, 12'b0};
    endfunction

    function automatic logic [XLEN-1:0] immJ(instWord_u w);
        return {{12{w.j.imm20}}, w.j.immHi, w.j.imm11, w.j.immLo, 1'b0};
    endfunction

endpackage

`default_nettype wire
